// ==== hdl/quasi_pkg.sv ====
// quasi boot shared definitions
`default_nettype none

package quasi_pkg;

	// bus and byte widths
	localparam int DATA_W = 32;
	localparam int BYTE_W = 8;
	localparam int BYTES_PER_WORD = DATA_W / BYTE_W;

	// boot ram, 1024 words
	localparam int RAM_AW = 10;
	localparam int RAM_DEPTH = 1 << RAM_AW;

	// receive buffer, 8 entries
	localparam int FIFO_AW = 3;
	localparam int FIFO_DEPTH = 1 << FIFO_AW;

	// uart bit timing, kept short for simulation
	localparam int CLKS_PER_BIT = 16;
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	localparam int BIT_IDX_W = $clog2(BYTE_W);

	// loader byte counting
	localparam int ADDR_BYTES = 2;
	localparam int LEFT_W = $clog2(BYTES_PER_WORD + 1);

	// boot command opcodes
	typedef enum logic [BYTE_W-1:0] {
		OP_SET_ADDR = 8'h41,
		OP_WRITE    = 8'h57
	} boot_op_t;

	// receiver states
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	// loader states
	typedef enum logic [1:0] {
		BOOT_CMD,
		BOOT_ADDR,
		BOOT_DATA
	} boot_state_t;

endpackage

`default_nettype wire

// ==== hdl/uart_rx.sv ====
// uart byte receiver
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input  wire                          clk,
	input  wire                          i_arst_n,
	input  wire                          i_rx,
	output logic [quasi_pkg::BYTE_W-1:0] o_byte,
	output logic                         o_byte_valid,
	output logic                         o_frame_err
);
	import quasi_pkg::*;

	rx_state_t            state;
	logic                 rx_meta;
	logic                 rx_sync;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [BIT_IDX_W-1:0] bit_idx;
	logic                 half_done;
	logic                 bit_done;

	// two-flop synchroniser, line idles high
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	// middle of start bit, then full bit periods
	assign half_done = bit_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);
	assign bit_done = bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= RX_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			o_byte_valid <= 1'b0;
			o_frame_err <= 1'b0;
		end else begin
			o_byte_valid <= 1'b0;
			bit_cnt <= bit_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					bit_cnt <= '0;
					if (!rx_sync)
						state <= RX_START;
				end
				RX_START: begin
					// a high line here was only a glitch
					if (half_done) begin
						bit_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (bit_done) begin
						bit_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == BIT_IDX_W'(BYTE_W - 1))
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (bit_done) begin
						state <= RX_IDLE;
						if (rx_sync)
							o_byte_valid <= 1'b1;
						else
							o_frame_err <= 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_done)
			o_byte <= {rx_sync, o_byte[BYTE_W-1:1]};
	end

endmodule

`default_nettype wire

// ==== hdl/byte_fifo.sv ====
// receive byte buffer
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
	input  wire                          clk,
	input  wire                          i_arst_n,
	input  wire                          i_wr,
	input  wire  [quasi_pkg::BYTE_W-1:0] i_wr_byte,
	input  wire                          i_pop,
	output logic [quasi_pkg::BYTE_W-1:0] o_rd_byte,
	output logic                         o_not_empty,
	output logic                         o_overrun
);
	import quasi_pkg::*;

	logic [BYTE_W-1:0]  mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               full;
	logic               push;
	logic               pull;

	// depth is a power of two, so the top count bit means full
	assign full = count[FIFO_AW];
	assign push = i_wr && !full;
	assign pull = i_pop && o_not_empty;

	assign o_not_empty = count != '0;
	assign o_rd_byte = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= i_wr_byte;
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_overrun <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pull)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pull})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// byte lost, flag stays until reset
			if (i_wr && full)
				o_overrun <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/serial_boot.sv ====
// serial boot command decoder
`timescale 1ns/1ps
`default_nettype none

module serial_boot (
	input  wire                          clk,
	input  wire                          i_arst_n,
	input  wire  [quasi_pkg::BYTE_W-1:0] i_byte,
	input  wire                          i_not_empty,
	input  wire                          i_boot_pause,
	output logic                         o_pop,
	output logic                         o_wr_en,
	output logic [quasi_pkg::RAM_AW-1:0] o_wr_addr,
	output logic [quasi_pkg::DATA_W-1:0] o_wr_data,
	output logic                         o_bad_cmd
);
	import quasi_pkg::*;

	boot_state_t                  state;
	logic [LEFT_W-1:0]            bytes_left;
	logic [DATA_W-1:0]            shift_reg;
	logic [RAM_AW-1:0]            load_addr;
	logic                         last_byte;
	logic [ADDR_BYTES*BYTE_W-1:0] new_addr;

	// one byte per cycle while data waits and the host allows it
	assign o_pop = i_not_empty && !i_boot_pause;

	assign last_byte = bytes_left == LEFT_W'(1);

	// high byte already shifted in, low byte on the bus
	assign new_addr = {shift_reg[BYTE_W-1:0], i_byte};

	// held stable through the write cycle
	assign o_wr_addr = load_addr;
	assign o_wr_data = shift_reg;

	// address and data bytes, msb first
	always_ff @(posedge clk) begin
		if (o_pop && state != BOOT_CMD)
			shift_reg <= {shift_reg[DATA_W-BYTE_W-1:0], i_byte};
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= BOOT_CMD;
			bytes_left <= '0;
			load_addr <= '0;
			o_wr_en <= 1'b0;
			o_bad_cmd <= 1'b0;
		end else begin
			o_wr_en <= 1'b0;

			// next word goes one above, wraps in ram
			if (o_wr_en)
				load_addr <= load_addr + 1'b1;

			if (o_pop) begin
				case (state)
					BOOT_CMD: begin
						case (i_byte)
							OP_SET_ADDR: begin
								state <= BOOT_ADDR;
								bytes_left <= LEFT_W'(ADDR_BYTES);
							end
							OP_WRITE: begin
								state <= BOOT_DATA;
								bytes_left <= LEFT_W'(BYTES_PER_WORD);
							end
							// unknown opcode is dropped
							default: o_bad_cmd <= 1'b1;
						endcase
					end
					BOOT_ADDR: begin
						bytes_left <= bytes_left - 1'b1;
						if (last_byte) begin
							// upper address bits beyond ram size ignored
							load_addr <= new_addr[RAM_AW-1:0];
							state <= BOOT_CMD;
						end
					end
					BOOT_DATA: begin
						bytes_left <= bytes_left - 1'b1;
						if (last_byte) begin
							o_wr_en <= 1'b1;
							state <= BOOT_CMD;
						end
					end
					default: state <= BOOT_CMD;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/boot_ram.sv ====
// boot word ram
`timescale 1ns/1ps
`default_nettype none

module boot_ram (
	input  wire                          clk,
	input  wire                          i_arst_n,
	input  wire                          i_wr_en,
	input  wire  [quasi_pkg::RAM_AW-1:0] i_wr_addr,
	input  wire  [quasi_pkg::DATA_W-1:0] i_wr_data,
	input  wire                          i_rd,
	input  wire  [quasi_pkg::RAM_AW-1:0] i_rd_addr,
	output logic [quasi_pkg::DATA_W-1:0] o_spo,
	output logic                         o_ready
);
	import quasi_pkg::*;

	logic [DATA_W-1:0] mem [RAM_DEPTH];

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	// read on the same edge as a write sees the old word
	always_ff @(posedge clk) begin
		if (i_rd)
			o_spo <= mem[i_rd_addr];
	end

	// one-cycle answer to each read strobe
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_ready <= 1'b0;
		else
			o_ready <= i_rd;
	end

endmodule

`default_nettype wire

// ==== hdl/quasi_boot_top.sv ====
// serial boot loader top
`timescale 1ns/1ps
`default_nettype none

module quasi_boot_top (
	input  wire                          clk,
	input  wire                          i_arst_n,
	input  wire                          i_uart_rx,
	input  wire                          i_boot_pause,
	input  wire                          i_rd,
	input  wire  [quasi_pkg::RAM_AW-1:0] i_rd_addr,
	output logic [quasi_pkg::DATA_W-1:0] o_spo,
	output logic                         o_ready,
	output logic                         o_overrun,
	output logic                         o_frame_err,
	output logic                         o_bad_cmd
);
	import quasi_pkg::*;

	// receiver to buffer
	logic [BYTE_W-1:0] rx_byte;
	logic              rx_valid;
	// buffer to loader
	logic [BYTE_W-1:0] fifo_byte;
	logic              fifo_not_empty;
	logic              fifo_pop;
	// loader to ram
	logic              ram_wr_en;
	logic [RAM_AW-1:0] ram_wr_addr;
	logic [DATA_W-1:0] ram_wr_data;

	uart_rx uart_rx_inst (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_rx(i_uart_rx),
		.o_byte(rx_byte),
		.o_byte_valid(rx_valid),
		.o_frame_err(o_frame_err)
	);

	byte_fifo byte_fifo_inst (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_wr(rx_valid),
		.i_wr_byte(rx_byte),
		.i_pop(fifo_pop),
		.o_rd_byte(fifo_byte),
		.o_not_empty(fifo_not_empty),
		.o_overrun(o_overrun)
	);

	serial_boot serial_boot_inst (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_byte(fifo_byte),
		.i_not_empty(fifo_not_empty),
		.i_boot_pause(i_boot_pause),
		.o_pop(fifo_pop),
		.o_wr_en(ram_wr_en),
		.o_wr_addr(ram_wr_addr),
		.o_wr_data(ram_wr_data),
		.o_bad_cmd(o_bad_cmd)
	);

	// host side read port, as the cpu would use after boot
	boot_ram boot_ram_inst (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_wr_en(ram_wr_en),
		.i_wr_addr(ram_wr_addr),
		.i_wr_data(ram_wr_data),
		.i_rd(i_rd),
		.i_rd_addr(i_rd_addr),
		.o_spo(o_spo),
		.o_ready(o_ready)
	);

endmodule

`default_nettype wire

// ==== test/tb_quasi_boot.sv ====
// serial boot loader testbench
`timescale 1ns/1ps
`default_nettype none

module tb_quasi_boot;
	import quasi_pkg::*;

	localparam logic [15:0] LFSR_SEED = 16'd38392;
	localparam int READ_TIMEOUT = 20;
	localparam int WORD_TIMEOUT = 50;

	logic              clk;
	logic              i_arst_n;
	logic              i_uart_rx;
	logic              i_boot_pause;
	logic              i_rd;
	logic [RAM_AW-1:0] i_rd_addr;
	logic [DATA_W-1:0] o_spo;
	logic              o_ready;
	logic              o_overrun;
	logic              o_frame_err;
	logic              o_bad_cmd;

	// reference model of the loader and the ram
	logic [DATA_W-1:0] exp_mem [RAM_DEPTH];
	boot_state_t       m_state;
	int                m_left;
	logic [DATA_W-1:0] m_shift;
	logic [RAM_AW-1:0] m_addr;
	logic              m_bad;
	logic              exp_ovr;
	logic              exp_fe;
	logic [15:0]       lfsr;

	quasi_boot_top quasi_boot_top_inst (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_uart_rx(i_uart_rx),
		.i_boot_pause(i_boot_pause),
		.i_rd(i_rd),
		.i_rd_addr(i_rd_addr),
		.o_spo(o_spo),
		.o_ready(o_ready),
		.o_overrun(o_overrun),
		.o_frame_err(o_frame_err),
		.o_bad_cmd(o_bad_cmd)
	);

	always #50 clk = ~clk;

	task automatic stop_run();
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic value_fail(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		stop_run();
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit of the word
	task automatic random_word(output logic [DATA_W-1:0] w);
		w = '0;
		for (int i = 0; i < DATA_W; i++) begin
			lfsr = lfsr_next(lfsr);
			w = {w[DATA_W-2:0], lfsr[0]};
		end
	endtask

	// protocol rule applied to one byte the loader will see
	task automatic model_byte(input logic [BYTE_W-1:0] b);
		case (m_state)
			BOOT_CMD: begin
				if (b == OP_SET_ADDR) begin
					m_state = BOOT_ADDR;
					m_left = 2;
				end else if (b == OP_WRITE) begin
					m_state = BOOT_DATA;
					m_left = 4;
				end else begin
					m_bad = 1'b1;
				end
			end
			default: begin
				m_shift = {m_shift[DATA_W-BYTE_W-1:0], b};
				m_left = m_left - 1;
				if (m_left == 0) begin
					if (m_state == BOOT_ADDR) begin
						m_addr = m_shift[RAM_AW-1:0];
					end else begin
						exp_mem[m_addr] = m_shift;
						m_addr = m_addr + 1'b1;
					end
					m_state = BOOT_CMD;
				end
			end
		endcase
	endtask

	task automatic drive_bit(input logic v);
		i_uart_rx = v;
		repeat (CLKS_PER_BIT) @(posedge clk);
		#1;
	endtask

	// start bit, data lsb first, stop bit
	task automatic uart_send(input logic [BYTE_W-1:0] b, input logic good_stop);
		drive_bit(1'b0);
		for (int i = 0; i < BYTE_W; i++)
			drive_bit(b[i]);
		drive_bit(good_stop);
		i_uart_rx = 1'b1;
	endtask

	task automatic send_byte(input logic [BYTE_W-1:0] b);
		uart_send(b, 1'b1);
		model_byte(b);
	endtask

	task automatic send_write(input logic [DATA_W-1:0] w);
		send_byte(OP_WRITE);
		for (int i = BYTES_PER_WORD - 1; i >= 0; i--)
			send_byte(w[i*BYTE_W +: BYTE_W]);
	endtask

	task automatic send_set_addr(input logic [15:0] a);
		send_byte(OP_SET_ADDR);
		send_byte(a[15:8]);
		send_byte(a[7:0]);
	endtask

	task automatic host_read(input logic [RAM_AW-1:0] addr, output logic [DATA_W-1:0] data);
		int waited;
		waited = 0;
		i_rd = 1'b1;
		i_rd_addr = addr;
		@(posedge clk);
		#1;
		i_rd = 1'b0;
		while (!o_ready) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > READ_TIMEOUT) begin
				$display("timeout: o_ready never came for read of address %0d", addr);
				stop_run();
			end
		end
		assert (waited == 0)
			else value_fail($sformatf("o_ready %0d cycles late at address %0d", waited, addr));
		data = o_spo;
		@(posedge clk);
		#1;
		assert (o_ready === 1'b0)
			else value_fail($sformatf("o_ready held past one cycle at address %0d", addr));
	endtask

	// a written word shows up only as a change in its read-back
	task automatic wait_for_word(input logic [RAM_AW-1:0] addr,
		input logic [DATA_W-1:0] old);
		logic [DATA_W-1:0] data;
		int tries;
		tries = 0;
		host_read(addr, data);
		while (data === old) begin
			tries++;
			if (tries > WORD_TIMEOUT) begin
				$display("timeout: word at address %0d was never written", addr);
				stop_run();
			end
			host_read(addr, data);
		end
	endtask

	task automatic check_range(input logic [RAM_AW-1:0] start, input int n);
		logic [RAM_AW-1:0] a;
		logic [DATA_W-1:0] data;
		for (int i = 0; i < n; i++) begin
			a = start + RAM_AW'(i);
			host_read(a, data);
			assert (data === exp_mem[a])
				else value_fail($sformatf("address %0d read %h, expected %h", a, data, exp_mem[a]));
		end
	endtask

	task automatic check_flags();
		assert (o_overrun === exp_ovr)
			else value_fail($sformatf("o_overrun %b, expected %b", o_overrun, exp_ovr));
		assert (o_frame_err === exp_fe)
			else value_fail($sformatf("o_frame_err %b, expected %b", o_frame_err, exp_fe));
		assert (o_bad_cmd === m_bad)
			else value_fail($sformatf("o_bad_cmd %b, expected %b", o_bad_cmd, m_bad));
	endtask

	initial begin
		logic [DATA_W-1:0] w;
		logic [DATA_W-1:0] old;
		logic [RAM_AW-1:0] first;
		logic [RAM_AW-1:0] last;
		clk = 1'b0;
		i_arst_n = 1'b0;
		i_uart_rx = 1'b1;
		i_boot_pause = 1'b0;
		i_rd = 1'b0;
		i_rd_addr = '0;
		lfsr = LFSR_SEED;
		m_state = BOOT_CMD;
		m_left = 0;
		m_shift = '0;
		m_addr = '0;
		m_bad = 1'b0;
		exp_ovr = 1'b0;
		exp_fe = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		i_arst_n = 1'b1;
		assert (o_ready === 1'b0) else value_fail("o_ready high after reset");
		check_flags();
		drive_bit(1'b1);

		// four writes from address zero
		last = RAM_AW'(3);
		host_read(last, old);
		for (int i = 0; i < 4; i++) begin
			random_word(w);
			send_write(w);
		end
		wait_for_word(last, old);
		check_range('0, 4);
		check_flags();

		// three writes after a set address
		first = 10'h123;
		last = first + RAM_AW'(2);
		host_read(last, old);
		send_set_addr(16'h0123);
		for (int i = 0; i < 3; i++) begin
			random_word(w);
			send_write(w);
		end
		wait_for_word(last, old);
		check_range(first, 3);
		// 0xfffe keeps only its low bits and the third word wraps to zero
		first = 10'h3FE;
		last = first + RAM_AW'(2);
		host_read(last, old);
		send_set_addr(16'hFFFE);
		for (int i = 0; i < 3; i++) begin
			random_word(w);
			send_write(w);
		end
		wait_for_word(last, old);
		check_range(first, 3);
		check_flags();

		// only the first eight bytes fit in the buffer while paused
		i_boot_pause = 1'b1;
		first = 10'h240;
		host_read(first, old);
		send_set_addr(16'h0240);
		random_word(w);
		send_write(w);
		random_word(w);
		uart_send(OP_WRITE, 1'b1);
		for (int i = BYTES_PER_WORD - 1; i > 0; i--)
			uart_send(w[i*BYTE_W +: BYTE_W], 1'b1);
		exp_ovr = 1'b1;
		check_flags();
		i_boot_pause = 1'b0;
		wait_for_word(first, old);
		check_range(first, 1);

		// the loader must not see a byte with a low stop bit
		uart_send(OP_WRITE, 1'b0);
		drive_bit(1'b1);
		exp_fe = 1'b1;
		check_flags();
		first = m_addr;
		host_read(first, old);
		random_word(w);
		send_write(w);
		wait_for_word(first, old);
		check_range(first, 1);

		// unknown opcode is dropped and flagged
		send_byte(8'hA5);
		first = m_addr;
		host_read(first, old);
		random_word(w);
		send_write(w);
		wait_for_word(first, old);
		check_range(first, 1);
		check_flags();

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/quasi_pkg.sv
hdl/uart_rx.sv
hdl/byte_fifo.sv
hdl/serial_boot.sv
hdl/boot_ram.sv
hdl/quasi_boot_top.sv
test/tb_quasi_boot.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module tb_quasi_boot --Mdir obj_dir

output=$(./obj_dir/Vtb_quasi_boot 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "STATUS: PASS"; then
	exit 0
fi
exit 1
